// File: common/fetch_bus.sv
`default_nettype none

interface fetch_bus
    import lc3b_pkg::*;
();

    logic     valid;     // one-cycle strobe, payload is only good with it.
    lc3b_word instr;
    lc3b_word pc;        // address of this instruction.
    lc3b_ctrl ctrl;
    lc3b_word offset6;   // already sign-extended.
    lc3b_word offset9;
    lc3b_word offset11;

    modport producer (
        output valid, instr, pc, ctrl, offset6, offset9, offset11
    );

    modport buffer (
        input valid, instr, pc, ctrl, offset6, offset9, offset11
    );

endinterface

`default_nettype wire

// File: common/ifid_bus.sv
`default_nettype none

interface ifid_bus
    import lc3b_pkg::*;
();

    logic       valid;      // one-cycle strobe.
    lc3b_word   pc;         // fetch pc plus two.
    lc3b_ctrl   ctrl;
    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    src1;
    lc3b_reg    src2;
    lc3b_word   imm5;       // sign-extended.
    lc3b_word   imm4;       // zero-extended.
    lc3b_word   trapvect8;  // vector times two.
    lc3b_word   offset6;
    lc3b_word   offset9;
    lc3b_word   offset11;

    modport buffer (
        output valid, pc, ctrl, opcode, dest, src1, src2,
        output imm5, imm4, trapvect8, offset6, offset9, offset11
    );

    modport consumer (
        input valid, pc, ctrl, opcode, dest, src1, src2,
        input imm5, imm4, trapvect8, offset6, offset9, offset11
    );

endinterface

`default_nettype wire

// File: common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    localparam int WORD_W   = 16;
    localparam int REG_W    = 3;
    localparam int CTRL_W   = 8;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0] lc3b_word;
    typedef logic [REG_W-1:0]  lc3b_reg;
    typedef logic [CTRL_W-1:0] lc3b_ctrl;  // all zero is a bubble.

    localparam lc3b_word PC_RESET = 16'h0000;

    // bit positions inside lc3b_ctrl.
    localparam int CTRL_REG_WRITE = 0;
    localparam int CTRL_USE_IMM   = 1;  // operand b comes from imm5.
    localparam int CTRL_SHIFT     = 2;  // operand b comes from imm4.
    localparam int CTRL_MEM_READ  = 3;
    localparam int CTRL_MEM_WRITE = 4;
    localparam int CTRL_BRANCH    = 5;
    localparam int CTRL_JUMP      = 6;
    localparam int CTRL_TRAP      = 7;

    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LDB  = 4'b0010,
        OP_STB  = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,
        OP_STI  = 4'b1011,
        OP_JMP  = 4'b1100,
        OP_SHF  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } lc3b_opcode;

endpackage

`default_nettype wire

// File: lc3b_frontend.f
common/lc3b_pkg.sv
common/fetch_bus.sv
common/ifid_bus.sv
verilog/lc3b_fetch.sv
verilog/lc3b_ifid.sv
verilog/lc3b_decode.sv
verilog/lc3b_frontend.sv
verif/lc3b_frontend_checker.sv
verif/lc3b_frontend_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the front-end simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f lc3b_frontend.f \
    --top-module lc3b_frontend_tb \
    -o sim_lc3b_frontend \
    && out=$(./obj_dir/sim_lc3b_frontend) \
    ; echo "$out" \
    && echo "$out" | grep -q "^all tests passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: verif/lc3b_frontend_checker.sv
`default_nettype none

module lc3b_frontend_checker (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic imem_read,
    input wire logic imem_resp,
    input wire logic redirect,
    input wire logic id_valid
);

    logic outstanding;  // a read was issued and its response has not come back.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            outstanding <= 1'b0;
        else if (imem_read)
            outstanding <= 1'b1;
        else if (imem_resp)
            outstanding <= 1'b0;
    end

    a_single_read: assert property (@(posedge clk) disable iff (!arst_n)
        imem_read |-> !outstanding)
        else $error("imem_read issued while a request is outstanding");

    a_redirect_flush: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !id_valid)
        else $error("id_valid seen in the cycle after redirect");

    a_quiet_reset: assert property (@(posedge clk)
        !arst_n |-> !(imem_read || id_valid))
        else $error("strobe seen during reset");

endmodule

bind lc3b_frontend lc3b_frontend_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_read (imem_read),
    .imem_resp (imem_resp),
    .redirect  (redirect),
    .id_valid  (id_valid)
);

`default_nettype wire

// File: verif/lc3b_frontend_tb.sv
`default_nettype none

module lc3b_frontend_tb;

    localparam int          NROWS        = 16;
    localparam int          WD_CYCLES    = NROWS * 20 + 200;
    localparam logic [15:0] FIRST_PC     = 16'h0000;
    localparam logic [15:0] REDIR_TRIG   = 16'h0014;  // the redirect follows one cycle after this read.
    localparam logic [15:0] REDIR_TARGET = 16'h0100;
    localparam logic [15:0] BYPASS_ADDR  = 16'h0108;

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] instr;
        logic        shown;   // 0 for bubbles and instructions lost to the redirect.
        logic [15:0] ctrl;
        logic [15:0] dest;
        logic [15:0] sr1;
        logic [15:0] opb;
        logic [15:0] offset;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        imem_read;
    logic [15:0] imem_addr;
    logic        imem_resp;
    logic [15:0] imem_rdata;
    logic        redirect;
    logic [15:0] redirect_pc;
    logic        wb_we;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic        id_valid;
    logic [15:0] id_pc;
    logic [7:0]  id_ctrl;
    logic [2:0]  id_dest;
    logic [15:0] id_sr1_val;
    logic [15:0] id_opb;
    logic [15:0] id_offset;

    row_t        rows [NROWS];
    integer      seed;
    logic [15:0] req_addr;
    logic        pending;
    int unsigned wait_cnt;
    int          bypass_cnt;
    logic [3:0]  init_reg;
    logic        first_read;
    logic        redirected;
    logic        redirect_due;

    lc3b_frontend u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // registers hold index times 16'h1111, r3 becomes 16'hbeef at the bypass row.
    task automatic fill_table();
        rows[0]  = '{16'h0000, 16'h1283, 1'b1, 16'h01, 16'd1, 16'h2222, 16'h3333, 16'h0000};
        rows[1]  = '{16'h0002, 16'h197d, 1'b1, 16'h03, 16'd4, 16'h5555, 16'hfffd, 16'h0000};
        rows[2]  = '{16'h0004, 16'h55c1, 1'b1, 16'h01, 16'd2, 16'h7777, 16'h1111, 16'h0000};
        rows[3]  = '{16'h0006, 16'h562f, 1'b1, 16'h03, 16'd3, 16'h0000, 16'h000f, 16'h0000};
        rows[4]  = '{16'h0008, 16'h9bbf, 1'b1, 16'h01, 16'd5, 16'h6666, 16'h7777, 16'h0000};
        rows[5]  = '{16'h000a, 16'h0000, 1'b0, 16'h00, 16'd0, 16'h0000, 16'h0000, 16'h0000};
        rows[6]  = '{16'h000c, 16'h0ffc, 1'b1, 16'h20, 16'd7, 16'h7777, 16'h4444, 16'hfffc};
        rows[7]  = '{16'h000e, 16'hec55, 1'b1, 16'h01, 16'd6, 16'h1111, 16'h5555, 16'h0055};
        rows[8]  = '{16'h0010, 16'h4f00, 1'b1, 16'h41, 16'd7, 16'h4444, 16'h0000, 16'hff00};
        rows[9]  = '{16'h0012, 16'h1241, 1'b0, 16'h00, 16'd0, 16'h0000, 16'h0000, 16'h0000};
        rows[10] = '{16'h0100, 16'hd285, 1'b1, 16'h07, 16'd1, 16'h2222, 16'h0005, 16'h0000};
        rows[11] = '{16'h0102, 16'h673e, 1'b1, 16'h09, 16'd3, 16'h4444, 16'h6666, 16'hfffe};
        rows[12] = '{16'h0104, 16'h3447, 1'b1, 16'h10, 16'd2, 16'h1111, 16'h7777, 16'h0007};
        rows[13] = '{16'h0106, 16'hf025, 1'b1, 16'h80, 16'd0, 16'h0000, 16'h5555, 16'h004a};
        rows[14] = '{16'h0108, 16'h10c3, 1'b1, 16'h01, 16'd0, 16'hbeef, 16'hbeef, 16'h0000};
        rows[15] = '{16'h010a, 16'h14e1, 1'b1, 16'h03, 16'd2, 16'hbeef, 16'h0001, 16'h0000};
    endtask

    function automatic logic [15:0] read_rom(input logic [15:0] addr);
        logic [15:0] data;
        data = 16'h0000;  // addresses outside the table read as bubbles.
        for (int i = 0; i < NROWS; i++)
        begin
            if (rows[i].addr == addr)
                data = rows[i].instr;
        end
        return data;
    endfunction

    // one falling-edge step of the memory model and the writeback driver.
    task automatic drive_step();
        int unsigned r;
        imem_resp = 1'b0;
        redirect  = 1'b0;
        wb_we     = 1'b0;
        if (redirect_due)
        begin
            redirect     = 1'b1;  // arrives while the previous word sits in the ifid stage.
            redirect_pc  = REDIR_TARGET;
            redirect_due = 1'b0;
        end
        if (init_reg < 4'd8)
        begin
            wb_we    = 1'b1;
            wb_reg   = init_reg[2:0];
            wb_data  = {4{init_reg}};
            init_reg = init_reg + 4'd1;
        end
        if (bypass_cnt > 0)
        begin
            bypass_cnt = bypass_cnt - 1;
            if (bypass_cnt == 0)
            begin
                wb_we   = 1'b1;  // lands in the cycle decode reads r3.
                wb_reg  = 3'd3;
                wb_data = 16'hbeef;
            end
        end
        if (pending && init_reg == 4'd8)
        begin
            if (wait_cnt > 1)
                wait_cnt = wait_cnt - 1;
            else
            begin
                imem_resp  = 1'b1;
                imem_rdata = read_rom(req_addr);
                pending    = 1'b0;
                if (req_addr == BYPASS_ADDR)
                    bypass_cnt = 2;
            end
        end
        if (imem_read)
        begin
            r        = $random(seed);
            req_addr = imem_addr;
            pending  = 1'b1;
            wait_cnt = 1 + r % 3;
            if (first_read)
            begin
                check("imem_addr", imem_addr, FIRST_PC);
                first_read = 1'b0;
            end
            if (imem_addr == REDIR_TRIG && !redirected)
            begin
                redirect_due = 1'b1;
                redirected   = 1'b1;
            end
        end
    endtask

    initial
    begin
        arst_n       = 1'b0;
        imem_resp    = 1'b0;
        imem_rdata   = 16'h0000;
        redirect     = 1'b0;
        redirect_pc  = 16'h0000;
        wb_we        = 1'b0;
        wb_reg       = 3'd0;
        wb_data      = 16'h0000;
        seed         = 32'hc5ae;
        pending      = 1'b0;
        wait_cnt     = 0;
        bypass_cnt   = 0;
        init_reg     = 4'd1;
        first_read   = 1'b1;
        redirected   = 1'b0;
        redirect_due = 1'b0;
        req_addr     = 16'h0000;
        fill_table();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        forever
        begin
            @(negedge clk);
            drive_step();
        end
    end

    initial
    begin
        repeat (2)
        begin
            @(negedge clk);
            check("imem_read", {15'd0, imem_read}, 16'd0);
            check("id_valid", {15'd0, id_valid}, 16'd0);
        end
        for (int i = 0; i < NROWS; i++)
        begin
            if (rows[i].shown)
            begin
                do
                    @(negedge clk);
                while (!id_valid);
                check("id_pc", id_pc, rows[i].addr + 16'd2);
                check("id_ctrl", {8'd0, id_ctrl}, rows[i].ctrl);
                check("id_dest", {13'd0, id_dest}, rows[i].dest);
                check("id_sr1_val", id_sr1_val, rows[i].sr1);
                check("id_opb", id_opb, rows[i].opb);
                check("id_offset", id_offset, rows[i].offset);
            end
        end
        repeat (20)
        begin
            @(negedge clk);
            check("id_valid", {15'd0, id_valid}, 16'd0);  // only bubbles are left.
        end
        $display("all tests passed");
        $finish;
    end

    initial
    begin
        #(WD_CYCLES * 10);
        $display("timeout: the expected decoded instructions did not all arrive");
        $display("tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: verilog/lc3b_decode.sv
`default_nettype none

module lc3b_decode
    import lc3b_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    ifid_bus.consumer ib,
    input  logic      wb_we,
    input  lc3b_reg   wb_reg,
    input  lc3b_word  wb_data,
    output logic      id_valid,
    output lc3b_word  id_pc,
    output lc3b_ctrl  id_ctrl,
    output lc3b_reg   id_dest,
    output lc3b_word  id_sr1_val,
    output lc3b_word  id_opb,
    output lc3b_word  id_offset
);

    lc3b_word regs [NUM_REGS];
    lc3b_word sr1_val;
    lc3b_word sr2_val;
    lc3b_word opb;
    lc3b_word offset;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_we)
        begin
            regs[wb_reg] <= wb_data;
        end
    end

    // a write in this cycle is forwarded to the read.
    assign sr1_val = (wb_we && wb_reg == ib.src1) ? wb_data : regs[ib.src1];
    assign sr2_val = (wb_we && wb_reg == ib.src2) ? wb_data : regs[ib.src2];

    always_comb
    begin
        if (ib.ctrl[CTRL_SHIFT])
            opb = ib.imm4;
        else if (ib.ctrl[CTRL_USE_IMM])
            opb = ib.imm5;
        else
            opb = sr2_val;
    end

    always_comb
    begin
        case (ib.opcode)
            OP_BR, OP_LEA, OP_LDI, OP_STI: offset = ib.offset9;
            OP_JSR:                        offset = ib.offset11;
            OP_LDB, OP_STB, OP_LDR, OP_STR: offset = ib.offset6;
            OP_TRAP:                       offset = ib.trapvect8;
            default:                       offset = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            id_valid <= 1'b0;
        else
            id_valid <= ib.valid && (ib.ctrl != '0) && !flush;  // bubbles stop here.
    end

    always_ff @(posedge clk)
    begin
        if (ib.valid)
        begin
            id_pc      <= ib.pc;
            id_ctrl    <= ib.ctrl;
            id_dest    <= ib.dest;
            id_sr1_val <= sr1_val;
            id_opb     <= opb;
            id_offset  <= offset;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lc3b_fetch.sv
`default_nettype none

module lc3b_fetch
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       redirect,
    input  lc3b_word   redirect_pc,
    output logic       imem_read,
    output lc3b_word   imem_addr,
    input  logic       imem_resp,
    input  lc3b_word   imem_rdata,
    fetch_bus.producer fb
);

    typedef enum logic {IDLE, WAIT} fetch_state_e;

    fetch_state_e state;     // WAIT means a read is outstanding.
    lc3b_word     pc;
    logic         read_q;
    logic         drop;      // a stale response is still owed.
    logic         accept;
    lc3b_opcode   opcode;
    lc3b_ctrl     ctrl;

    assign imem_read = read_q;
    assign imem_addr = pc;
    assign accept    = imem_resp && (state == WAIT) && !redirect;
    assign opcode    = lc3b_opcode'(imem_rdata[15:12]);

    always_comb
    begin
        ctrl = '0;
        case (opcode)
            OP_BR:   ctrl[CTRL_BRANCH] = 1'b1;
            OP_ADD, OP_AND:
            begin
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_USE_IMM]   = imem_rdata[5];  // immediate form.
            end
            OP_NOT, OP_LEA: ctrl[CTRL_REG_WRITE] = 1'b1;
            OP_SHF:
            begin
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_SHIFT]     = 1'b1;
                ctrl[CTRL_USE_IMM]   = 1'b1;
            end
            OP_LDB, OP_LDR, OP_LDI:
            begin
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_MEM_READ]  = 1'b1;
            end
            OP_STB, OP_STR, OP_STI: ctrl[CTRL_MEM_WRITE] = 1'b1;
            OP_JSR:
            begin
                ctrl[CTRL_REG_WRITE] = 1'b1;  // link goes to r7.
                ctrl[CTRL_JUMP]      = 1'b1;
            end
            OP_JMP, OP_RTI: ctrl[CTRL_JUMP] = 1'b1;
            OP_TRAP: ctrl[CTRL_TRAP] = 1'b1;
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            pc       <= PC_RESET;
            read_q   <= 1'b0;
            drop     <= 1'b0;
            fb.valid <= 1'b0;
        end
        else
        begin
            read_q   <= 1'b0;
            fb.valid <= accept;
            if (redirect)
            begin
                state <= IDLE;
                pc    <= redirect_pc;
                drop  <= (state == WAIT || drop) && !imem_resp;
            end
            else if (state == IDLE)
            begin
                if (!drop || imem_resp)  // old response gone, free to issue.
                begin
                    state  <= WAIT;
                    read_q <= 1'b1;
                    drop   <= 1'b0;
                end
            end
            else if (imem_resp)
            begin
                pc     <= pc + 16'd2;
                read_q <= 1'b1;  // next request goes out with the strobe.
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            fb.instr    <= imem_rdata;
            fb.pc       <= pc;
            fb.ctrl     <= ctrl;
            fb.offset6  <= {{10{imem_rdata[5]}}, imem_rdata[5:0]};
            fb.offset9  <= {{7{imem_rdata[8]}}, imem_rdata[8:0]};
            fb.offset11 <= {{5{imem_rdata[10]}}, imem_rdata[10:0]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/lc3b_frontend.sv
`default_nettype none

module lc3b_frontend
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    output logic     imem_read,
    output lc3b_word imem_addr,
    input  logic     imem_resp,
    input  lc3b_word imem_rdata,

    input  logic     redirect,
    input  lc3b_word redirect_pc,

    input  logic     wb_we,
    input  lc3b_reg  wb_reg,
    input  lc3b_word wb_data,

    output logic     id_valid,
    output lc3b_word id_pc,
    output lc3b_ctrl id_ctrl,
    output lc3b_reg  id_dest,
    output lc3b_word id_sr1_val,
    output lc3b_word id_opb,
    output lc3b_word id_offset
);

    fetch_bus fb_if ();
    ifid_bus  ib_if ();

    lc3b_fetch u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_read   (imem_read),
        .imem_addr   (imem_addr),
        .imem_resp   (imem_resp),
        .imem_rdata  (imem_rdata),
        .fb          (fb_if)
    );

    // a redirect also empties the two later stages.
    lc3b_ifid u_ifid (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (redirect),
        .fb     (fb_if),
        .ib     (ib_if)
    );

    lc3b_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (redirect),
        .ib         (ib_if),
        .wb_we      (wb_we),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_ctrl    (id_ctrl),
        .id_dest    (id_dest),
        .id_sr1_val (id_sr1_val),
        .id_opb     (id_opb),
        .id_offset  (id_offset)
    );

endmodule

`default_nettype wire

// File: verilog/lc3b_ifid.sv
`default_nettype none

module lc3b_ifid
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    fetch_bus.buffer fb,
    ifid_bus.buffer  ib
);

    logic bubble;

    assign bubble = (fb.instr == '0);  // the all-zero word is a nop, not a branch.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ib.valid     <= 1'b0;
            ib.pc        <= '0;
            ib.ctrl      <= '0;
            ib.opcode    <= OP_BR;
            ib.dest      <= '0;
            ib.src1      <= '0;
            ib.src2      <= '0;
            ib.imm5      <= '0;
            ib.imm4      <= '0;
            ib.trapvect8 <= '0;
            ib.offset6   <= '0;
            ib.offset9   <= '0;
            ib.offset11  <= '0;
        end
        else if (flush)
        begin
            ib.valid     <= 1'b0;
            ib.pc        <= '0;
            ib.ctrl      <= '0;
            ib.opcode    <= OP_BR;
            ib.dest      <= '0;
            ib.src1      <= '0;
            ib.src2      <= '0;
            ib.imm5      <= '0;
            ib.imm4      <= '0;
            ib.trapvect8 <= '0;
            ib.offset6   <= '0;
            ib.offset9   <= '0;
            ib.offset11  <= '0;
        end
        else
        begin
            ib.valid <= fb.valid;
            if (fb.valid)
            begin
                ib.pc        <= fb.pc + 16'd2;  // pc seen downstream is already advanced.
                ib.ctrl      <= bubble ? '0 : fb.ctrl;
                ib.opcode    <= lc3b_opcode'(fb.instr[15:12]);
                ib.dest      <= fb.instr[11:9];
                ib.src1      <= fb.instr[8:6];
                ib.src2      <= fb.instr[2:0];
                ib.imm5      <= {{11{fb.instr[4]}}, fb.instr[4:0]};
                ib.imm4      <= {12'd0, fb.instr[3:0]};
                ib.trapvect8 <= {7'd0, fb.instr[7:0], 1'b0};
                ib.offset6   <= fb.offset6;
                ib.offset9   <= fb.offset9;
                ib.offset11  <= fb.offset11;
            end
        end
    end

endmodule

`default_nettype wire
